// File: verilog/io_bus_pkg.sv
package io_bus_pkg;

	localparam int addr_width = 16;
	localparam int data_width = 32;
	localparam int byte_width = 8;
	localparam int irq_count = 16;

	// the PC port space is 64K ports wide
	typedef logic [addr_width-1:0] io_addr_t;

	typedef logic [data_width-1:0] io_data_t;

	typedef logic [byte_width-1:0] io_byte_t;

	// transfer size in bytes, the CPU side only issues 1, 2 and 4
	typedef logic [2:0] io_len_t;

	typedef logic [irq_count-1:0] irq_vec_t;

endpackage

// File: verilog/io_map_pkg.sv
package io_map_pkg;

	import io_bus_pkg::*;

	// device groups in read mux priority order, byte devices first
	typedef enum logic [3:0] {
		dev_floppy,
		dev_dma,
		dev_pic,
		dev_pit,
		dev_ps2,
		dev_rtc,
		dev_sound,
		dev_uart1,
		dev_uart2,
		dev_mpu,
		dev_vga,
		dev_joy,
		dev_ide0,
		dev_ide1,
		dev_sysctl
	} dev_index_e;

	typedef logic [int'(dev_sysctl):0] dev_sel_t;

	localparam int byte_dev_count = int'(dev_ide0);

	// mask widths give the number of low address bits ignored by a range
	localparam int unsigned exact_bits = 0;
	localparam int unsigned ide_cmd_bits = 3;
	localparam int unsigned floppy_bits = 2;
	localparam int unsigned floppy_dir_bits = 1;
	localparam int unsigned dma_slave_bits = 4;
	localparam int unsigned dma_page_bits = 4;
	localparam int unsigned dma_master_bits = 5;
	localparam int unsigned pic_bits = 1;
	localparam int unsigned pit_bits = 2;
	localparam int unsigned ps2_io_bits = 3;
	localparam int unsigned ps2_ctl_bits = 4;
	localparam int unsigned rtc_bits = 1;
	localparam int unsigned sb_bits = 4;
	localparam int unsigned fm_bits = 2;
	localparam int unsigned uart_bits = 3;
	localparam int unsigned mpu_bits = 1;
	localparam int unsigned vga_bits = 4;

	localparam io_addr_t ide0_cmd_base = 16'h01F0;
	localparam io_addr_t ide0_ctl_port = 16'h03F6;
	localparam io_addr_t ide1_cmd_base = 16'h0170;
	localparam io_addr_t ide1_ctl_port = 16'h0376;
	localparam io_addr_t joy_port = 16'h0201;
	localparam io_addr_t floppy_base = 16'h03F0;
	localparam io_addr_t floppy_dir_base = 16'h03F4;
	localparam io_addr_t floppy_ccr_port = 16'h03F7;
	localparam io_addr_t dma_slave_base = 16'h0000;
	localparam io_addr_t dma_page_base = 16'h0080;
	localparam io_addr_t dma_master_base = 16'h00C0;
	localparam io_addr_t pic_master_base = 16'h0020;
	localparam io_addr_t pic_slave_base = 16'h00A0;
	localparam io_addr_t pit_base = 16'h0040;
	// port 61h is shared between the speaker gate and the keyboard controller
	localparam io_addr_t pit_speaker_port = 16'h0061;
	localparam io_addr_t ps2_io_base = 16'h0060;
	localparam io_addr_t ps2_ctl_base = 16'h0090;
	localparam io_addr_t rtc_base = 16'h0070;
	localparam io_addr_t sb_base = 16'h0220;
	localparam io_addr_t fm_base = 16'h0388;
	localparam io_addr_t uart1_base = 16'h03F8;
	localparam io_addr_t uart2_base = 16'h02F8;
	localparam io_addr_t mpu_base = 16'h0330;
	localparam io_addr_t vga_b_base = 16'h03B0;
	localparam io_addr_t vga_c_base = 16'h03C0;
	localparam io_addr_t vga_d_base = 16'h03D0;
	localparam io_addr_t sysctl_addr = 16'h8888;

endpackage

// File: verilog/port_decode.sv
module port_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  io_bus_pkg::io_addr_t  dev_address,
	output io_map_pkg::dev_sel_t  dev_sel,
	output logic                  io32_target
);
	import io_bus_pkg::*;
	import io_map_pkg::*;

	dev_sel_t sel_next;
	logic     io32_next;

	function automatic logic port_hit(io_addr_t addr, io_addr_t base, int unsigned bits);
		io_addr_t mask;
		mask = ~((io_addr_t'(1) << bits) - io_addr_t'(1));
		return (addr & mask) == base;
	endfunction

	always_comb begin
		sel_next = '0;
		sel_next[dev_floppy] = port_hit(dev_address, floppy_base, floppy_bits) ||
			port_hit(dev_address, floppy_dir_base, floppy_dir_bits) ||
			port_hit(dev_address, floppy_ccr_port, exact_bits);
		sel_next[dev_dma] = port_hit(dev_address, dma_slave_base, dma_slave_bits) ||
			port_hit(dev_address, dma_page_base, dma_page_bits) ||
			port_hit(dev_address, dma_master_base, dma_master_bits);
		sel_next[dev_pic] = port_hit(dev_address, pic_master_base, pic_bits) ||
			port_hit(dev_address, pic_slave_base, pic_bits);
		sel_next[dev_pit] = port_hit(dev_address, pit_base, pit_bits) ||
			port_hit(dev_address, pit_speaker_port, exact_bits);
		sel_next[dev_ps2] = port_hit(dev_address, ps2_io_base, ps2_io_bits) ||
			port_hit(dev_address, ps2_ctl_base, ps2_ctl_bits);
		sel_next[dev_rtc] = port_hit(dev_address, rtc_base, rtc_bits);
		sel_next[dev_sound] = port_hit(dev_address, sb_base, sb_bits) ||
			port_hit(dev_address, fm_base, fm_bits);
		sel_next[dev_uart1] = port_hit(dev_address, uart1_base, uart_bits);
		sel_next[dev_uart2] = port_hit(dev_address, uart2_base, uart_bits);
		sel_next[dev_mpu] = port_hit(dev_address, mpu_base, mpu_bits);
		sel_next[dev_vga] = port_hit(dev_address, vga_b_base, vga_bits) ||
			port_hit(dev_address, vga_c_base, vga_bits) ||
			port_hit(dev_address, vga_d_base, vga_bits);
		sel_next[dev_joy] = port_hit(dev_address, joy_port, exact_bits);
		sel_next[dev_ide0] = port_hit(dev_address, ide0_cmd_base, ide_cmd_bits) ||
			port_hit(dev_address, ide0_ctl_port, exact_bits);
		sel_next[dev_ide1] = port_hit(dev_address, ide1_cmd_base, ide_cmd_bits) ||
			port_hit(dev_address, ide1_ctl_port, exact_bits);
		sel_next[dev_sysctl] = port_hit(dev_address, sysctl_addr, exact_bits);
	end

	// the IDE data block is word wide, its control port at 3x6h stays a byte port
	assign io32_next = ((sel_next[dev_ide0] || sel_next[dev_ide1]) && !dev_address[9]) ||
		sel_next[dev_sysctl];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dev_sel <= '0;
			io32_target <= 1'b0;
		end else begin
			dev_sel <= sel_next;
			io32_target <= io32_next;
		end
	end

endmodule

// File: verilog/bus_cycle.sv
module bus_cycle (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  io_bus_pkg::io_addr_t  paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  io_bus_pkg::io_data_t  pwdata,
	input  io_bus_pkg::io_len_t   io_length,
	output io_bus_pkg::io_data_t  prdata,
	output logic                  pready,
	output io_bus_pkg::io_addr_t  dev_address,
	output io_bus_pkg::io_data_t  dev_writedata,
	output io_bus_pkg::io_len_t   dev_datasize,
	output logic                  dev_read,
	output logic                  dev_write,
	input  logic                  io32_target,
	input  io_bus_pkg::io_byte_t  byte_readdata,
	input  io_bus_pkg::io_data_t  word_readdata
);
	import io_bus_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_address,
		st_strobe,
		st_done
	} state_e;

	state_e     state;
	logic       accept;
	logic       write_q;
	io_len_t    length_q;
	io_data_t   wdata_q;
	io_data_t   rdata_q;
	logic [1:0] lane;
	logic       last_cycle;

	// a request is taken in its APB setup phase
	assign accept = (state == st_idle) && psel && !penable;

	// word targets finish in one cycle, byte targets after io_length cycles
	assign last_cycle = io32_target || (io_len_t'(lane) + io_len_t'(1) >= length_q);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
			write_q <= 1'b0;
			lane <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_address;
						write_q <= pwrite;
						lane <= '0;
					end
				end
				st_address: begin
					// dev_sel and io32_target settle during this cycle
					state <= st_strobe;
				end
				st_strobe: begin
					if (last_cycle) begin
						state <= st_done;
					end else begin
						state <= st_address;
						lane <= lane + 2'd1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			dev_address <= paddr;
			length_q <= io_length;
			wdata_q <= pwdata;
			rdata_q <= '0;
		end else if (state == st_strobe) begin
			if (!write_q) begin
				if (io32_target) begin
					rdata_q <= word_readdata;
				end else begin
					rdata_q[{lane, 3'b000} +: 8] <= byte_readdata;
				end
			end
			if (!last_cycle) begin
				dev_address <= dev_address + io_addr_t'(1);
			end
		end
	end

	// byte k of the write word moves down to the low lane for cycle k
	assign dev_writedata = wdata_q >> {lane, 3'b000};
	assign dev_datasize = io32_target ? length_q : io_len_t'(1);

	assign dev_read = (state == st_strobe) && !write_q;
	assign dev_write = (state == st_strobe) && write_q;

	assign pready = (state == st_done);
	assign prdata = rdata_q;

endmodule

// File: verilog/response_collect.sv
module response_collect (
	input  io_map_pkg::dev_sel_t                  dev_sel,
	input  logic [io_map_pkg::byte_dev_count*8-1:0] dev_readdata,
	input  io_bus_pkg::io_data_t                  ide0_readdata,
	input  io_bus_pkg::io_data_t                  ide1_readdata,
	output io_bus_pkg::io_byte_t                  byte_readdata,
	output io_bus_pkg::io_data_t                  word_readdata,
	input  io_bus_pkg::irq_vec_t                  irq_in,
	output io_bus_pkg::irq_vec_t                  irq_out
);
	import io_bus_pkg::*;
	import io_map_pkg::*;

	localparam io_byte_t no_device = 8'hFF;

	// the lowest selected group wins, so port 61h answers with the pit byte
	always_comb begin
		byte_readdata = no_device;
		// IDE control ports read as bytes return the low lane of their word
		if (dev_sel[dev_ide1]) begin
			byte_readdata = ide1_readdata[7:0];
		end
		if (dev_sel[dev_ide0]) begin
			byte_readdata = ide0_readdata[7:0];
		end
		for (int i = byte_dev_count - 1; i >= 0; i--) begin
			if (dev_sel[i]) begin
				byte_readdata = dev_readdata[i*8 +: 8];
			end
		end
	end

	always_comb begin
		if (dev_sel[dev_ide0]) begin
			word_readdata = ide0_readdata;
		end else if (dev_sel[dev_ide1]) begin
			word_readdata = ide1_readdata;
		end else begin
			word_readdata = io_data_t'(byte_readdata);
		end
	end

	// the cascade input on line 2 is served through line 9
	always_comb begin
		irq_out = irq_in;
		irq_out[9] = irq_in[9] | irq_in[2];
		irq_out[2] = 1'b0;
		irq_out[11] = 1'b0;
		irq_out[13] = 1'b0;
	end

endmodule

// File: verilog/sysctl_port.sv
module sysctl_port #(
	parameter io_bus_pkg::io_byte_t reset_value = 8'hA2,
	parameter io_bus_pkg::io_byte_t unlock_key = 8'hA1
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  io_map_pkg::dev_sel_t  dev_sel,
	input  logic                  dev_read,
	input  logic                  dev_write,
	input  io_bus_pkg::io_len_t   dev_datasize,
	input  io_bus_pkg::io_data_t  dev_writedata,
	output io_bus_pkg::io_byte_t  syscfg
);
	import io_bus_pkg::*;
	import io_map_pkg::*;

	logic in_reset;
	logic disk_access;
	logic unlock_write;

	assign disk_access = (dev_read || dev_write) &&
		(dev_sel[dev_ide0] || dev_sel[dev_ide1] || dev_sel[dev_floppy]);

	// only a 16-bit write with the key in the high byte reaches the register
	assign unlock_write = dev_write && dev_sel[dev_sysctl] &&
		(dev_datasize == io_len_t'(2)) && (dev_writedata[15:8] == unlock_key);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg <= reset_value;
			in_reset <= 1'b1;
		end else if (disk_access && in_reset) begin
			// boot firmware has reached the disks, drop the power-on value
			syscfg <= '0;
			in_reset <= 1'b0;
		end else if (unlock_write) begin
			syscfg <= dev_writedata[7:0];
			in_reset <= 1'b0;
		end
	end

endmodule

// File: verilog/io_hub.sv
module io_hub #(
	parameter io_bus_pkg::io_byte_t sysctl_reset_value = 8'hA2,
	parameter io_bus_pkg::io_byte_t sysctl_unlock_key = 8'hA1
) (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  io_bus_pkg::io_addr_t                   paddr,
	input  logic                                   psel,
	input  logic                                   penable,
	input  logic                                   pwrite,
	input  io_bus_pkg::io_data_t                   pwdata,
	input  io_bus_pkg::io_len_t                    io_length,
	output io_bus_pkg::io_data_t                   prdata,
	output logic                                   pready,
	output io_bus_pkg::io_addr_t                   dev_address,
	output io_bus_pkg::io_data_t                   dev_writedata,
	output io_bus_pkg::io_len_t                    dev_datasize,
	output logic                                   dev_read,
	output logic                                   dev_write,
	output io_map_pkg::dev_sel_t                   dev_sel,
	input  logic [io_map_pkg::byte_dev_count*8-1:0] dev_readdata,
	input  io_bus_pkg::io_data_t                   ide0_readdata,
	input  io_bus_pkg::io_data_t                   ide1_readdata,
	input  io_bus_pkg::irq_vec_t                   irq_in,
	output io_bus_pkg::irq_vec_t                   irq_out,
	output io_bus_pkg::io_byte_t                   syscfg
);
	import io_bus_pkg::*;

	logic     io32_target;
	io_byte_t byte_readdata;
	io_data_t word_readdata;

	port_decode decode0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dev_address (dev_address),
		.dev_sel     (dev_sel),
		.io32_target (io32_target)
	);

	bus_cycle cycle0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.io_length     (io_length),
		.prdata        (prdata),
		.pready        (pready),
		.dev_address   (dev_address),
		.dev_writedata (dev_writedata),
		.dev_datasize  (dev_datasize),
		.dev_read      (dev_read),
		.dev_write     (dev_write),
		.io32_target   (io32_target),
		.byte_readdata (byte_readdata),
		.word_readdata (word_readdata)
	);

	response_collect collect0 (
		.dev_sel       (dev_sel),
		.dev_readdata  (dev_readdata),
		.ide0_readdata (ide0_readdata),
		.ide1_readdata (ide1_readdata),
		.byte_readdata (byte_readdata),
		.word_readdata (word_readdata),
		.irq_in        (irq_in),
		.irq_out       (irq_out)
	);

	sysctl_port #(
		.reset_value (sysctl_reset_value),
		.unlock_key  (sysctl_unlock_key)
	) sysctl0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dev_sel       (dev_sel),
		.dev_read      (dev_read),
		.dev_write     (dev_write),
		.dev_datasize  (dev_datasize),
		.dev_writedata (dev_writedata),
		.syscfg        (syscfg)
	);

endmodule

// File: verification/io_hub_tb.sv
module io_hub_tb;
	import io_bus_pkg::*;
	import io_map_pkg::*;

	localparam io_byte_t reset_value = 8'hA2;
	localparam io_byte_t unlock_key = 8'hA1;
	localparam int transfer_timeout = 100;

	logic clk_sys = 1'b0;
	logic reset;
	io_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	io_data_t pwdata;
	io_len_t io_length;
	io_data_t prdata;
	logic pready;
	io_addr_t dev_address;
	io_data_t dev_writedata;
	io_len_t dev_datasize;
	logic dev_read;
	logic dev_write;
	dev_sel_t dev_sel;
	logic [byte_dev_count*8-1:0] dev_readdata;
	io_data_t ide0_readdata;
	io_data_t ide1_readdata;
	irq_vec_t irq_in;
	irq_vec_t irq_out;
	io_byte_t syscfg;

	integer seed = 74252;
	int read_strobes = 0;
	io_addr_t write_addr_log[$];
	io_byte_t write_byte_log[$];
	dev_sel_t strobe_sel;
	io_len_t strobe_size;

	io_hub #(
		.sysctl_reset_value (reset_value),
		.sysctl_unlock_key  (unlock_key)
	) dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.io_length     (io_length),
		.prdata        (prdata),
		.pready        (pready),
		.dev_address   (dev_address),
		.dev_writedata (dev_writedata),
		.dev_datasize  (dev_datasize),
		.dev_read      (dev_read),
		.dev_write     (dev_write),
		.dev_sel       (dev_sel),
		.dev_readdata  (dev_readdata),
		.ide0_readdata (ide0_readdata),
		.ide1_readdata (ide1_readdata),
		.irq_in        (irq_in),
		.irq_out       (irq_out),
		.syscfg        (syscfg)
	);

	always #5 clk_sys = ~clk_sys;

	// byte group g answers with its index in the high nibble and the port offset in the low one
	function automatic io_byte_t model_byte(int group, io_addr_t addr);
		return 8'(group * 16) + {4'h0, addr[3:0]};
	endfunction

	function automatic io_data_t ide0_word(io_addr_t addr);
		return 32'h1D0A_0000 + {16'h0000, addr};
	endfunction

	function automatic io_data_t ide1_word(io_addr_t addr);
		return 32'h1D1B_0000 + {16'h0000, addr};
	endfunction

	function automatic dev_sel_t group_sel(int group);
		return dev_sel_t'(1) << group;
	endfunction

	for (genvar g = 0; g < byte_dev_count; g++) begin : byte_model
		assign dev_readdata[g*8 +: 8] = model_byte(g, dev_address);
	end

	assign ide0_readdata = ide0_word(dev_address);
	assign ide1_readdata = ide1_word(dev_address);

	always @(negedge clk_sys) begin
		if (dev_write) begin
			write_addr_log.push_back(dev_address);
			write_byte_log.push_back(dev_writedata[7:0]);
			$display("write strobe at %h data %h", dev_address, dev_writedata[7:0]);
		end
		if (dev_read) begin
			read_strobes++;
		end
		// the last strobe of a transfer leaves its select and size here
		if (dev_read || dev_write) begin
			strobe_sel = dev_sel;
			strobe_size = dev_datasize;
		end
	end

	task automatic check_value(input string name, input io_data_t expected,
		input io_data_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic strobe_check(input string name, input dev_sel_t sel, input io_len_t size);
		check_value({name, " select"}, {17'h0, sel}, {17'h0, strobe_sel});
		check_value({name, " size"}, {29'h0, size}, {29'h0, strobe_size});
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic apb_transfer(input io_addr_t addr, input logic write, input io_data_t wdata,
		input io_len_t len, output io_data_t rdata);
		int cycles;
		cycles = 0;
		@(negedge clk_sys);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		io_length = len;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk_sys);
		penable = 1'b1;
		while (!pready) begin
			if (cycles == transfer_timeout) begin
				$display("APB transfer at port %h never saw pready", addr);
				$display("sim failed");
				$fatal(1, "transfer timeout");
			end
			@(negedge clk_sys);
			cycles++;
		end
		rdata = prdata;
		// the access phase ends at the edge after pready was seen
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reset_outputs();
		check_value("reset syscfg", {24'h0, reset_value}, {24'h0, syscfg});
		check_value("reset dev_read", 32'h0, 32'(dev_read));
		check_value("reset dev_write", 32'h0, 32'(dev_write));
		check_value("reset pready", 32'h0, 32'(pready));
	endtask

	task automatic byte_reads();
		io_addr_t addrs [21];
		int groups [21];
		io_data_t rdata;
		addrs = '{16'h03F2, 16'h03F5, 16'h03F7, 16'h0008, 16'h0085, 16'h00C3,
			16'h0021, 16'h00A1, 16'h0042, 16'h0064, 16'h0095, 16'h0071, 16'h022A,
			16'h038A, 16'h03FB, 16'h02FC, 16'h0331, 16'h03B4, 16'h03C5, 16'h03DA,
			16'h0201};
		groups = '{0, 0, 0, 1, 1, 1, 2, 2, 3, 4, 4, 5, 6, 6, 7, 8, 9, 10, 10, 10, 11};
		for (int i = 0; i < 21; i++) begin
			apb_transfer(addrs[i], 1'b0, 32'h0, 3'd1, rdata);
			check_value($sformatf("byte read %h", addrs[i]),
				{24'h0, model_byte(groups[i], addrs[i])}, rdata);
			strobe_check($sformatf("byte read %h", addrs[i]), group_sel(groups[i]), 3'd1);
		end
		// pit and ps2 both decode 61h and pit comes first
		apb_transfer(16'h0061, 1'b0, 32'h0, 3'd1, rdata);
		check_value("byte read 0061", {24'h0, model_byte(3, 16'h0061)}, rdata);
		strobe_check("byte read 0061", group_sel(3) | group_sel(4), 3'd1);
		apb_transfer(16'h0300, 1'b0, 32'h0, 3'd1, rdata);
		check_value("unmapped read 0300", 32'h0000_00FF, rdata);
		strobe_check("unmapped read 0300", '0, 3'd1);
		apb_transfer(16'h03F6, 1'b0, 32'h0, 3'd1, rdata);
		check_value("ide control read 03F6", ide0_word(16'h03F6) & 32'h0000_00FF, rdata);
		strobe_check("ide control read 03F6", group_sel(dev_ide0), 3'd1);
		apb_transfer(16'h0376, 1'b0, 32'h0, 3'd1, rdata);
		check_value("ide control read 0376", ide1_word(16'h0376) & 32'h0000_00FF, rdata);
		strobe_check("ide control read 0376", group_sel(dev_ide1), 3'd1);
	endtask

	task automatic split_cycles();
		io_data_t rdata;
		io_data_t wdata;
		int strobes_before;
		int log_before;
		strobes_before = read_strobes;
		apb_transfer(16'h03F8, 1'b0, 32'h0, 3'd2, rdata);
		check_value("split read 03F8",
			{16'h0, model_byte(7, 16'h03F9), model_byte(7, 16'h03F8)}, rdata);
		check_value("split read strobes", 32'd2, 32'(read_strobes - strobes_before));
		strobe_check("split read 03F9", group_sel(7), 3'd1);
		wdata = $random(seed);
		log_before = write_addr_log.size();
		apb_transfer(16'h0020, 1'b1, wdata, 3'd4, rdata);
		check_value("split write strobes", 32'd4, 32'(write_addr_log.size() - log_before));
		// port 23h lies past the pic range
		strobe_check("split write 0023", '0, 3'd1);
		for (int k = 0; k < 4; k++) begin
			check_value($sformatf("split write address %0d", k),
				{16'h0, 16'h0020 + 16'(k)}, {16'h0, write_addr_log[log_before + k]});
			check_value($sformatf("split write byte %0d", k), {24'h0, wdata[k*8 +: 8]},
				{24'h0, write_byte_log[log_before + k]});
		end
	endtask

	task automatic word_reads();
		io_data_t rdata;
		int strobes_before;
		strobes_before = read_strobes;
		apb_transfer(16'h01F0, 1'b0, 32'h0, 3'd4, rdata);
		check_value("ide0 word read", ide0_word(16'h01F0), rdata);
		check_value("ide0 word strobes", 32'd1, 32'(read_strobes - strobes_before));
		strobe_check("ide0 word read", group_sel(dev_ide0), 3'd4);
		apb_transfer(16'h0170, 1'b0, 32'h0, 3'd4, rdata);
		check_value("ide1 word read", ide1_word(16'h0170), rdata);
		strobe_check("ide1 word read", group_sel(dev_ide1), 3'd4);
	endtask

	task automatic sysctl_access();
		io_data_t rdata;
		io_data_t rnd;
		io_byte_t cfg;
		apply_reset();
		check_value("sysctl after reset", {24'h0, reset_value}, {24'h0, syscfg});
		apb_transfer(16'h03F0, 1'b0, 32'h0, 3'd1, rdata);
		check_value("sysctl disk clear", 32'h0, {24'h0, syscfg});
		rnd = $random(seed);
		// a nonzero value tells a load apart from the disk clear
		cfg = rnd[7:0] | 8'h01;
		apb_transfer(16'h8888, 1'b1, {16'h0, unlock_key, cfg}, 3'd2, rdata);
		check_value("sysctl keyed write", {24'h0, cfg}, {24'h0, syscfg});
		strobe_check("sysctl keyed write", group_sel(dev_sysctl), 3'd2);
		apb_transfer(16'h8888, 1'b1, {16'h0, 8'h5A, ~cfg}, 3'd2, rdata);
		check_value("sysctl wrong key", {24'h0, cfg}, {24'h0, syscfg});
		apb_transfer(16'h8888, 1'b1, {16'h0, unlock_key, ~cfg}, 3'd1, rdata);
		check_value("sysctl byte write", {24'h0, cfg}, {24'h0, syscfg});
		strobe_check("sysctl byte write", group_sel(dev_sysctl), 3'd1);
		// later disk accesses leave the register alone
		apb_transfer(16'h03F0, 1'b0, 32'h0, 3'd1, rdata);
		check_value("sysctl second disk access", {24'h0, cfg}, {24'h0, syscfg});
	endtask

	task automatic irq_routing();
		io_data_t rnd;
		irq_vec_t expected;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			@(negedge clk_sys);
			irq_in = (i == 0) ? 16'h0004 : rnd[15:0];
			@(posedge clk_sys);
			// lines 13, 11 and 2 are not routed and a request on line 2 shows on line 9
			expected = irq_in & ~16'h2804;
			if (irq_in[2]) begin
				expected[9] = 1'b1;
			end
			check_value($sformatf("irq pattern %h", irq_in), {16'h0, expected},
				{16'h0, irq_out});
		end
	endtask

	initial begin
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		io_length = 3'd1;
		irq_in = '0;
		apply_reset();
		reset_outputs();
		byte_reads();
		split_cycles();
		word_reads();
		sysctl_access();
		irq_routing();
		$display("sim passed");
		$finish;
	end

endmodule

// File: io_hub.f
verilog/io_bus_pkg.sv
verilog/io_map_pkg.sv
verilog/port_decode.sv
verilog/bus_cycle.sv
verilog/response_collect.sv
verilog/sysctl_port.sv
verilog/io_hub.sv
verification/io_hub_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the io_hub testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module io_hub_tb \
	--Mdir obj_dir -o io_hub_sim -f io_hub.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/io_hub_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
